// ==== Makefile ====
# Verilator build and run for the DVI transmitter testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module dviTransmitter_tb -f sources.f -o dviTransmitter_sim

# The run fails unless the simulation output holds the pass line
run: compile
	@out="$$(./obj_dir/dviTransmitter_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== hdl/dviTimingPkg.sv ====
/* Fixed video mode for the DVI link: raster lengths, sync polarity,
   derived totals and the counter widths sized from them */
package dviTimingPkg;

	// Horizontal raster in pixel clocks
	// The mode is kept tiny so a whole frame is only a few hundred cycles
	localparam int H_ACTIVE = 16;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 4;
	localparam int H_BACK = 2;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int H_SYNC_END = H_SYNC_START + H_SYNC;

	// Vertical raster in lines
	localparam int V_ACTIVE = 4;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 1;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
	localparam int V_SYNC_END = V_SYNC_START + V_SYNC;

	// Both sync pulses are high while asserted
	localparam logic SYNC_ACTIVE = 1'b1;

	// Counter and position widths, 5 and 3 bits for this mode
	localparam int H_COUNT_WIDTH = $clog2(H_TOTAL);
	localparam int V_COUNT_WIDTH = $clog2(V_TOTAL);

endpackage

// ==== hdl/dviTransmitter.sv ====
/* DVI transmitter top: timing generator, three TMDS encoders,
   three serializers and the forwarded clock channel */
`timescale 1ns/1ns

module dviTransmitter
	import dviTimingPkg::*;
	import tmdsPkg::*;
(
	input logic PixelClk,
	input logic SerialClk,
	input logic rstN,
	input logic [PIXEL_WIDTH-1:0] red,
	input logic [PIXEL_WIDTH-1:0] green,
	input logic [PIXEL_WIDTH-1:0] blue,
	output logic de,
	output logic [H_COUNT_WIDTH-1:0] pixelX,
	output logic [V_COUNT_WIDTH-1:0] pixelY,
	output logic [CHANNEL_COUNT-1:0] tmdsData_p,
	output logic [CHANNEL_COUNT-1:0] tmdsData_n,
	output logic tmdsClk_p,
	output logic tmdsClk_n
);

	videoSyncIf syncBus();

	logic [PIXEL_WIDTH-1:0] chanPixel [CHANNEL_COUNT];
	logic [1:0] chanCtrl [CHANNEL_COUNT];
	tmdsSymbol chanSymbol [CHANNEL_COUNT];

	// --------------------------------------------------
	// Raster timing
	// --------------------------------------------------
	videoTimingGen timingGen (
		.PixelClk(PixelClk),
		.rstN(rstN),
		.sync(syncBus)
	);

	// The source answers the pixel request in the same cycle
	assign de = syncBus.de;
	assign pixelX = syncBus.pixelX;
	assign pixelY = syncBus.pixelY;

	// Channel 0 is blue, 1 green, 2 red
	assign chanPixel[0] = blue;
	assign chanPixel[1] = green;
	assign chanPixel[2] = red;

	// Only the blue channel carries the syncs as {c1,c0}
	assign chanCtrl[0] = {syncBus.vSync, syncBus.hSync};
	assign chanCtrl[1] = 2'b00;
	assign chanCtrl[2] = 2'b00;

	// --------------------------------------------------
	// Data channels
	// --------------------------------------------------
	for (genvar ch = 0; ch < CHANNEL_COUNT; ch++)
	begin : gChannel
		tmdsEncoder encoder (
			.PixelClk(PixelClk),
			.rstN(rstN),
			.sync(syncBus),
			.pixel(chanPixel[ch]),
			.ctrl(chanCtrl[ch]),
			.symbol(chanSymbol[ch])
		);

		outputSerdes serdes (
			.PixelClk(PixelClk),
			.SerialClk(SerialClk),
			.rstN(rstN),
			.symbol(chanSymbol[ch]),
			.serialOut(tmdsData_p[ch])
		);
	end

	// Each pair is modeled as a signal and its complement
	assign tmdsData_n = ~tmdsData_p;

	// Clock channel is the pixel clock itself
	assign tmdsClk_p = PixelClk;
	assign tmdsClk_n = ~PixelClk;

endmodule

// ==== hdl/outputSerdes.sv ====
/* Behavioral 10:1 serializer from the pixel domain to the
   serial domain, least significant bit first */
`timescale 1ns/1ns

module outputSerdes
	import tmdsPkg::*;
(
	input logic PixelClk,
	input logic SerialClk,
	input logic rstN,
	input tmdsSymbol symbol,
	output logic serialOut
);

	tmdsSymbol symbolQ;
	logic [1:0] rstSync;
	logic serialRstN;
	logic [$clog2(SYMBOL_WIDTH)-1:0] phase;
	logic [SYMBOL_WIDTH-1:0] shiftReg;

	// Holding register in the pixel domain, stable for a whole pixel period
	always_ff @(posedge PixelClk)
		symbolQ <= symbol;

	// Two-flop resynchronizer for reset into the serial domain
	always_ff @(posedge SerialClk)
		rstSync <= {rstSync[0], rstN};

	assign serialRstN = rstSync[1];

	// --------------------------------------------------
	// Serial domain
	// --------------------------------------------------
	// SerialClk is phase-locked at ten times PixelClk and rstN is released
	// on a PixelClk edge, so phase 0 falls a fixed few serial cycles after
	// a pixel edge, well inside the period where symbolQ is stable
	// That makes the capture below safe by construction with no CDC logic
	always_ff @(posedge SerialClk)
	begin
		if (!serialRstN)
		begin
			phase <= '0;
			shiftReg <= '0;
		end
		else
		begin
			if (phase == ($clog2(SYMBOL_WIDTH))'(SYMBOL_WIDTH - 1))
				phase <= '0;
			else
				phase <= phase + 1'b1;
			// Reload once per symbol, otherwise move the next bit down
			if (phase == '0)
				shiftReg <= symbolQ.raw;
			else
				shiftReg <= {1'b0, shiftReg[SYMBOL_WIDTH-1:1]};
		end
	end

	// Bit 0 goes out first, and stays 0 while the serial reset is held
	assign serialOut = shiftReg[0];

endmodule

// ==== hdl/tmdsEncoder.sv ====
/* Two-stage TMDS 8b/10b encoder with running disparity and
   control token insertion during blanking */
`timescale 1ns/1ns

module tmdsEncoder
	import tmdsPkg::*;
(
	input logic PixelClk,
	input logic rstN,
	videoSyncIf.sink sync,
	input logic [PIXEL_WIDTH-1:0] pixel,
	input logic [1:0] ctrl,
	output tmdsSymbol symbol
);

	// Stage 1 signals
	logic useXnor;
	logic [PIXEL_WIDTH-1:0] tmWord;
	logic xorModeQ;
	logic [PIXEL_WIDTH-1:0] payloadQ;
	logic deQ;
	logic [1:0] ctrlQ;

	// Stage 2 signals
	logic signed [DISPARITY_WIDTH-1:0] disparity;
	logic signed [DISPARITY_WIDTH-1:0] nextDisparity;
	tmdsSymbol dataSymbol;
	tmdsSymbol ctrlSymbol;

	// --------------------------------------------------
	// Stage 1: transition minimization
	// --------------------------------------------------
	always_comb
	begin : transitionMin
		logic [3:0] ones;
		logic [PIXEL_WIDTH-1:0] chain;
		ones = '0;
		for (int i = 0; i < PIXEL_WIDTH; i++)
			ones = ones + 4'(pixel[i]);
		// XNOR chaining gives fewer transitions for ones-heavy pixels
		useXnor = (ones > 4'd4) || ((ones == 4'd4) && !pixel[0]);
		chain[0] = pixel[0];
		for (int i = 1; i < PIXEL_WIDTH; i++)
			chain[i] = useXnor ? ~(chain[i-1] ^ pixel[i]) : (chain[i-1] ^ pixel[i]);
		tmWord = chain;
	end

	// Word travels with its own de and ctrl so blanking lines up in stage 2
	always_ff @(posedge PixelClk)
	begin
		payloadQ <= tmWord;
		xorModeQ <= ~useXnor;
		if (!rstN)
		begin
			deQ <= 1'b0;
			ctrlQ <= 2'b00;
		end
		else
		begin
			deQ <= sync.de;
			ctrlQ <= ctrl;
		end
	end

	// --------------------------------------------------
	// Stage 2: DC balance per DVI 1.0
	// --------------------------------------------------
	always_comb
	begin : dcBalance
		logic [3:0] ones;
		logic signed [DISPARITY_WIDTH-1:0] balance;
		logic signed [DISPARITY_WIDTH-1:0] xorTwice;
		logic signed [DISPARITY_WIDTH-1:0] xnorTwice;
		ones = '0;
		for (int i = 0; i < PIXEL_WIDTH; i++)
			ones = ones + 4'(payloadQ[i]);
		// Ones minus zeros of the payload, that is 2*ones - 8
		balance = $signed({{(DISPARITY_WIDTH-5){1'b0}}, ones, 1'b0})
			- $signed(DISPARITY_WIDTH'(PIXEL_WIDTH));
		xorTwice = $signed({{(DISPARITY_WIDTH-2){1'b0}}, xorModeQ, 1'b0});
		xnorTwice = $signed({{(DISPARITY_WIDTH-2){1'b0}}, ~xorModeQ, 1'b0});
		dataSymbol.fields.xorMode = xorModeQ;
		if ((disparity == 0) || (balance == 0))
		begin
			// Neutral case, xorMode alone decides the inversion
			dataSymbol.fields.inverted = ~xorModeQ;
			dataSymbol.fields.payload = xorModeQ ? payloadQ : ~payloadQ;
			nextDisparity = xorModeQ ? disparity + balance : disparity - balance;
		end
		else if ((disparity > 0) == (balance > 0))
		begin
			// Same sign would grow the imbalance, so send the complement
			dataSymbol.fields.inverted = 1'b1;
			dataSymbol.fields.payload = ~payloadQ;
			nextDisparity = disparity + xorTwice - balance;
		end
		else
		begin
			dataSymbol.fields.inverted = 1'b0;
			dataSymbol.fields.payload = payloadQ;
			nextDisparity = disparity - xnorTwice + balance;
		end
	end

	// Token picked by this channel's {c1,c0}
	always_comb
	begin
		case (ctrlQ)
			2'b00: ctrlSymbol.raw = CTRL_TOKEN_00;
			2'b01: ctrlSymbol.raw = CTRL_TOKEN_01;
			2'b10: ctrlSymbol.raw = CTRL_TOKEN_10;
			default: ctrlSymbol.raw = CTRL_TOKEN_11;
		endcase
	end

	// Output register, disparity restarts from zero after every blanking symbol
	always_ff @(posedge PixelClk)
	begin
		if (!rstN)
		begin
			symbol.raw <= CTRL_TOKEN_00;
			disparity <= '0;
		end
		else if (deQ)
		begin
			symbol <= dataSymbol;
			disparity <= nextDisparity;
		end
		else
		begin
			symbol <= ctrlSymbol;
			disparity <= '0;
		end
	end

endmodule

// ==== hdl/tmdsPkg.sv ====
/* TMDS link constants: symbol and pixel widths, DVI control tokens,
   and the packed union with the raw and field views of a symbol */
package tmdsPkg;

	// One 10-bit symbol per pixel clock on each channel
	localparam int SYMBOL_WIDTH = 10;
	localparam int PIXEL_WIDTH = 8;

	// Blue, green and red data channels
	localparam int CHANNEL_COUNT = 3;

	// Signed running disparity, comfortably wider than the DVI bound
	localparam int DISPARITY_WIDTH = 6;

	// --------------------------------------------------
	// Control tokens sent during blanking, indexed by {c1,c0}
	// Bit 0 is the first bit on the wire
	// --------------------------------------------------
	localparam logic [SYMBOL_WIDTH-1:0] CTRL_TOKEN_00 = 10'b1101010100;
	localparam logic [SYMBOL_WIDTH-1:0] CTRL_TOKEN_01 = 10'b0010101011;
	localparam logic [SYMBOL_WIDTH-1:0] CTRL_TOKEN_10 = 10'b0101010100;
	localparam logic [SYMBOL_WIDTH-1:0] CTRL_TOKEN_11 = 10'b1010101011;

	// Field layout of a data symbol
	// inverted marks a complemented payload, xorMode marks XOR chaining
	typedef struct packed {
		logic inverted;
		logic xorMode;
		logic [PIXEL_WIDTH-1:0] payload;
	} tmdsFields;

	// Same 10 bits seen as a plain word or as decoded fields
	// Control tokens are written through raw, data symbols through fields
	typedef union packed {
		logic [SYMBOL_WIDTH-1:0] raw;
		tmdsFields fields;
	} tmdsSymbol;

endpackage

// ==== hdl/videoSyncIf.sv ====
/* Raster bus between the timing generator and the channel encoders */
`timescale 1ns/1ns

interface videoSyncIf
	import dviTimingPkg::*;
();

	// Active video level, doubles as the pixel request
	logic de;
	logic hSync;
	logic vSync;

	// Raster position, meaningful only while de is high
	logic [H_COUNT_WIDTH-1:0] pixelX;
	logic [V_COUNT_WIDTH-1:0] pixelY;

	// Timing generator side drives everything
	modport timing (output de, output hSync, output vSync, output pixelX, output pixelY);

	// Encoders only need the levels
	modport sink (input de, input hSync, input vSync);

endinterface

// ==== hdl/videoTimingGen.sv ====
/* Raster timing generator: horizontal and vertical counters with
   registered de, hSync, vSync and pixel position */
`timescale 1ns/1ns

module videoTimingGen
	import dviTimingPkg::*;
(
	input logic PixelClk,
	input logic rstN,
	videoSyncIf.timing sync
);

	logic [H_COUNT_WIDTH-1:0] hCount;
	logic [V_COUNT_WIDTH-1:0] vCount;
	logic lineEnd;
	logic frameEnd;
	logic inActive;
	logic inHSync;
	logic inVSync;

	// --------------------------------------------------
	// Raster decode from the current counter position
	// --------------------------------------------------
	assign lineEnd = hCount == H_COUNT_WIDTH'(H_TOTAL - 1);
	assign frameEnd = vCount == V_COUNT_WIDTH'(V_TOTAL - 1);

	// Active region sits at the start of both axes, so (0,0) is the first pixel
	assign inActive = (hCount < H_COUNT_WIDTH'(H_ACTIVE))
		&& (vCount < V_COUNT_WIDTH'(V_ACTIVE));

	// Sync windows follow the front porch on each axis
	assign inHSync = (hCount >= H_COUNT_WIDTH'(H_SYNC_START))
		&& (hCount < H_COUNT_WIDTH'(H_SYNC_END));
	assign inVSync = (vCount >= V_COUNT_WIDTH'(V_SYNC_START))
		&& (vCount < V_COUNT_WIDTH'(V_SYNC_END));

	// One position per pixel clock, line counter steps at the end of each line
	always_ff @(posedge PixelClk)
	begin
		if (!rstN)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (lineEnd)
		begin
			hCount <= '0;
			if (frameEnd)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
		end
		else
		begin
			hCount <= hCount + 1'b1;
		end
	end

	// --------------------------------------------------
	// Registered outputs
	// --------------------------------------------------
	// Everything for one location is sampled from the same counter value
	// so de, the syncs and the position always line up
	always_ff @(posedge PixelClk)
	begin
		if (!rstN)
		begin
			sync.de <= 1'b0;
			sync.hSync <= ~SYNC_ACTIVE;
			sync.vSync <= ~SYNC_ACTIVE;
			sync.pixelX <= '0;
			sync.pixelY <= '0;
		end
		else
		begin
			sync.de <= inActive;
			sync.hSync <= inHSync ? SYNC_ACTIVE : ~SYNC_ACTIVE;
			sync.vSync <= inVSync ? SYNC_ACTIVE : ~SYNC_ACTIVE;
			sync.pixelX <= hCount;
			sync.pixelY <= vCount;
		end
	end

endmodule

// ==== sim/dviTransmitter_asserts.sv ====
/* Concurrent checks on the raster timing generator and the bind
   that attaches them to every videoTimingGen instance */
`timescale 1ns/1ns

module dviTransmitter_asserts
	import dviTimingPkg::*;
(
	input logic PixelClk,
	input logic rstN,
	input logic de,
	input logic hSync,
	input logic vSync,
	input logic [H_COUNT_WIDTH-1:0] pixelX,
	input logic [V_COUNT_WIDTH-1:0] pixelY
);

	// Active video never overlaps either sync pulse
	deOutsideSync: assert property (@(posedge PixelClk) disable iff (!rstN)
		de |-> (hSync != SYNC_ACTIVE) && (vSync != SYNC_ACTIVE))
		else $error("de is high during a sync pulse");

	// The published position lies inside the raster
	// and inside the active window while de is high
	positionInRange: assert property (@(posedge PixelClk) disable iff (!rstN)
		(pixelX < H_TOTAL) && (!de || ((pixelX < H_ACTIVE) && (pixelY < V_ACTIVE))))
		else $error("raster position outside the frame");

	// de is registered, so it is low one edge after reset is seen
	deLowInReset: assert property (@(posedge PixelClk) !rstN |=> !de)
		else $error("de is high while reset is held");

endmodule

bind videoTimingGen dviTransmitter_asserts timingChecks (
	.PixelClk(PixelClk),
	.rstN(rstN),
	.de(sync.de),
	.hSync(sync.hSync),
	.vSync(sync.vSync),
	.pixelX(sync.pixelX),
	.pixelY(sync.pixelY)
);

// ==== sim/dviTransmitter_tb.sv ====
/* DVI transmitter testbench: clocks, reset, random pixel source,
   serial deserializer with word lock, reference TMDS encoder and checks */
`timescale 1ns/1ns

module dviTransmitter_tb
	import dviTimingPkg::*;
	import tmdsPkg::*;
();

	// Wait limits in pixel clocks
	localparam int LOCK_TIMEOUT = 2000;
	localparam int RUN_TIMEOUT = 2000;
	localparam int FRAMES_TO_CHECK = 3;
	localparam int BALANCE_LIMIT = 10;

	// One raster location as presented to the DUT
	typedef struct packed {
		logic de;
		logic hSync;
		logic vSync;
		logic [PIXEL_WIDTH-1:0] red;
		logic [PIXEL_WIDTH-1:0] green;
		logic [PIXEL_WIDTH-1:0] blue;
	} rasterEntry;

	logic PixelClk;
	logic SerialClk;
	logic rstN;
	logic [PIXEL_WIDTH-1:0] red;
	logic [PIXEL_WIDTH-1:0] green;
	logic [PIXEL_WIDTH-1:0] blue;
	logic de;
	logic [H_COUNT_WIDTH-1:0] pixelX;
	logic [V_COUNT_WIDTH-1:0] pixelY;
	logic [CHANNEL_COUNT-1:0] tmdsData_p;
	logic [CHANNEL_COUNT-1:0] tmdsData_n;
	logic tmdsClk_p;
	logic tmdsClk_n;

	rasterEntry rasterQ [$];
	logic [SYMBOL_WIDTH-1:0] window [CHANNEL_COUNT];
	int matchRun [SYMBOL_WIDTH];
	int bitPhase;
	int lockPhase;
	logic locked;
	logic aligned;
	logic sawVsyncWord;
	logic prevVsyncWord;
	int refDisparity [CHANNEL_COUNT];
	int lineBalance [CHANNEL_COUNT];
	int runLength [CHANNEL_COUNT];
	int lineCount [CHANNEL_COUNT];
	int framesChecked;
	int hPos;
	int vPos;
	int checkErrors;
	int timeoutErrors;

	dviTransmitter dut (.*);

	// Both clocks start low at time 0, serial runs ten times faster
	initial
	begin
		PixelClk = 1'b0;
		forever #10 PixelClk = ~PixelClk;
	end

	initial
	begin
		SerialClk = 1'b0;
		forever #1 SerialClk = ~SerialClk;
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		assert (got === expected)
		else
		begin
			checkErrors++;
			$display("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
				$time, what, got, expected);
		end
	endtask

	function automatic logic isToken(input logic [SYMBOL_WIDTH-1:0] word);
		return (word === CTRL_TOKEN_00) || (word === CTRL_TOKEN_01)
			|| (word === CTRL_TOKEN_10) || (word === CTRL_TOKEN_11);
	endfunction

	// DVI control token table with c1 as the upper index bit
	function automatic logic [SYMBOL_WIDTH-1:0] tokenFor(input logic [1:0] c);
		case (c)
			2'b00: return CTRL_TOKEN_00;
			2'b01: return CTRL_TOKEN_01;
			2'b10: return CTRL_TOKEN_10;
			default: return CTRL_TOKEN_11;
		endcase
	endfunction

	function automatic logic [PIXEL_WIDTH-1:0] channelPixel(input rasterEntry entry,
		input int ch);
		case (ch)
			0: return entry.blue;
			1: return entry.green;
			default: return entry.red;
		endcase
	endfunction

	// Undo the inversion first, then the XOR or XNOR chain
	function automatic logic [PIXEL_WIDTH-1:0] decodeSymbol(
		input logic [SYMBOL_WIDTH-1:0] word);
		logic [PIXEL_WIDTH-1:0] q;
		logic [PIXEL_WIDTH-1:0] d;
		q = word[9] ? ~word[7:0] : word[7:0];
		d[0] = q[0];
		for (int i = 1; i < PIXEL_WIDTH; i++)
			d[i] = word[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
		return d;
	endfunction

	// DVI 1.0 encoder whose count tracks ones minus zeros of every sent symbol
	task automatic encodeReference(input int ch, input logic [PIXEL_WIDTH-1:0] d,
		output logic [SYMBOL_WIDTH-1:0] sym);
		logic [8:0] qm;
		int n1;
		int n0;
		n1 = $countones(d);
		qm[0] = d[0];
		// Bit 8 of qm is clear for the XNOR chain
		if ((n1 > 4) || ((n1 == 4) && !d[0]))
		begin
			for (int i = 1; i < 8; i++)
				qm[i] = qm[i-1] ~^ d[i];
			qm[8] = 1'b0;
		end
		else
		begin
			for (int i = 1; i < 8; i++)
				qm[i] = qm[i-1] ^ d[i];
			qm[8] = 1'b1;
		end
		n1 = $countones(qm[7:0]);
		n0 = 8 - n1;
		if ((refDisparity[ch] == 0) || (n1 == n0))
		begin
			sym = {~qm[8], qm[8], (qm[8] ? qm[7:0] : ~qm[7:0])};
			refDisparity[ch] += qm[8] ? (n1 - n0) : (n0 - n1);
		end
		else if ((refDisparity[ch] > 0 && n1 > n0) || (refDisparity[ch] < 0 && n0 > n1))
		begin
			sym = {1'b1, qm[8], ~qm[7:0]};
			refDisparity[ch] += (qm[8] ? 2 : 0) + n0 - n1;
		end
		else
		begin
			sym = {1'b0, qm[8], qm[7:0]};
			refDisparity[ch] += n1 - n0 - (qm[8] ? 0 : 2);
		end
	endtask

	// --------------------------------------------------
	// Raster model and pixel source
	// --------------------------------------------------
	// Runs from the first edge after reset, where the DUT shows (0,0)
	task automatic driveRaster();
		rasterEntry entry;
		forever
		begin
			@(posedge PixelClk);
			#2;
			entry.de = (hPos < H_ACTIVE) && (vPos < V_ACTIVE);
			entry.hSync = (hPos >= H_ACTIVE + H_FRONT) && (hPos < H_ACTIVE + H_FRONT + H_SYNC);
			entry.vSync = (vPos >= V_ACTIVE + V_FRONT) && (vPos < V_ACTIVE + V_FRONT + V_SYNC);
			checkValue(de, entry.de, "de");
			if (entry.de)
			begin
				checkValue(pixelX, hPos, "pixelX");
				checkValue(pixelY, vPos, "pixelY");
			end
			// New pixel only on a request while blanking keeps zeros
			entry.red = entry.de ? 8'($urandom) : '0;
			entry.green = entry.de ? 8'($urandom) : '0;
			entry.blue = entry.de ? 8'($urandom) : '0;
			red = entry.red;
			green = entry.green;
			blue = entry.blue;
			rasterQ.push_back(entry);
			hPos = (hPos + 1) % H_TOTAL;
			if (hPos == 0)
				vPos = (vPos + 1) % V_TOTAL;
		end
	endtask

	// --------------------------------------------------
	// Word checks after lock
	// --------------------------------------------------
	task automatic checkWord();
		logic [SYMBOL_WIDTH-1:0] expected;
		rasterEntry entry;
		logic vsyncWord;
		logic queueVsync;
		vsyncWord = (window[0] === CTRL_TOKEN_10) || (window[0] === CTRL_TOKEN_11);
		if (!aligned)
		begin
			// Start on the first data symbol that follows a vSync run
			if (vsyncWord)
				sawVsyncWord = 1'b1;
			if (!sawVsyncWord || isToken(window[0]))
				return;
			aligned = 1'b1;
			queueVsync = 1'b0;
			entry = rasterQ.pop_front();
			while ((rasterQ.size() > 0) && !(queueVsync && entry.de))
			begin
				queueVsync = queueVsync || entry.vSync;
				entry = rasterQ.pop_front();
			end
		end
		else
			entry = rasterQ.pop_front();
		for (int ch = 0; ch < CHANNEL_COUNT; ch++)
		begin
			if (entry.de)
			begin
				encodeReference(ch, channelPixel(entry, ch), expected);
				checkValue(window[ch], expected, $sformatf("ch%0d data symbol", ch));
				checkValue(decodeSymbol(window[ch]), channelPixel(entry, ch),
					$sformatf("ch%0d decoded pixel", ch));
				lineBalance[ch] += 2 * $countones(window[ch]) - SYMBOL_WIDTH;
				assert ((lineBalance[ch] <= BALANCE_LIMIT) && (lineBalance[ch] >= -BALANCE_LIMIT))
				else
				begin
					checkErrors++;
					$display("CHECK FAILED at %0t ns: ch%0d line disparity %0d out of range",
						$time, ch, lineBalance[ch]);
				end
			end
			else
			begin
				// Blanking restarts the disparity on both sides of the link
				refDisparity[ch] = 0;
				lineBalance[ch] = 0;
				expected = (ch == 0) ? tokenFor({entry.vSync, entry.hSync}) : CTRL_TOKEN_00;
				checkValue(window[ch], expected, $sformatf("ch%0d control token", ch));
			end
			// Line lengths come from the received words alone
			if (!isToken(window[ch]))
				runLength[ch]++;
			else if (runLength[ch] > 0)
			begin
				checkValue(runLength[ch], H_ACTIVE, $sformatf("ch%0d data symbols per line", ch));
				lineCount[ch]++;
				runLength[ch] = 0;
			end
		end
		// A new vSync run closes the frame
		if (vsyncWord && !prevVsyncWord)
		begin
			for (int ch = 0; ch < CHANNEL_COUNT; ch++)
			begin
				checkValue(lineCount[ch], V_ACTIVE, $sformatf("ch%0d active lines", ch));
				lineCount[ch] = 0;
			end
			framesChecked++;
		end
		prevVsyncWord = vsyncWord;
	endtask

	// Serial outputs change on the rising edge, so sample on the falling one
	always @(negedge SerialClk)
	begin
		if (rstN)
		begin
			for (int ch = 0; ch < CHANNEL_COUNT; ch++)
				window[ch] = {tmdsData_p[ch], window[ch][SYMBOL_WIDTH-1:1]};
			checkValue(tmdsData_n, CHANNEL_COUNT'(~tmdsData_p), "tmdsData_n");
			bitPhase = (bitPhase + 1) % SYMBOL_WIDTH;
			// Ten tokens in a row at one bit phase mark the word boundary
			if (!locked)
			begin
				matchRun[bitPhase] = isToken(window[0]) ? matchRun[bitPhase] + 1 : 0;
				if (matchRun[bitPhase] == 10)
				begin
					locked = 1'b1;
					lockPhase = bitPhase;
				end
			end
			else if (bitPhase == lockPhase)
				checkWord();
		end
	end

	// Pixel clock edges never meet a serial rising edge
	always @(posedge SerialClk)
	begin
		checkValue(tmdsClk_p, PixelClk, "tmdsClk_p");
		checkValue(tmdsClk_n, !PixelClk, "tmdsClk_n");
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial
	begin
		int waitCycles;
		void'($urandom(32'hd824_22dd));
		rstN = 1'b0;
		red = '0;
		green = '0;
		blue = '0;
		foreach (matchRun[i])
			matchRun[i] = 0;
		for (int ch = 0; ch < CHANNEL_COUNT; ch++)
		begin
			refDisparity[ch] = 0;
			lineBalance[ch] = 0;
			runLength[ch] = 0;
			lineCount[ch] = 0;
		end
		bitPhase = 0;
		lockPhase = 0;
		framesChecked = 0;
		hPos = 0;
		vPos = 0;
		locked = 1'b0;
		aligned = 1'b0;
		sawVsyncWord = 1'b0;
		prevVsyncWord = 1'b0;
		checkErrors = 0;
		timeoutErrors = 0;
		repeat (3) @(posedge PixelClk);
		#2;
		rstN = 1'b1;
		fork
			driveRaster();
		join_none
		waitCycles = 0;
		while (!locked && (waitCycles < LOCK_TIMEOUT))
		begin
			@(posedge PixelClk);
			waitCycles++;
		end
		if (!locked)
		begin
			timeoutErrors++;
			$display("Timeout: no word lock found on the blue channel control tokens");
		end
		else
		begin
			waitCycles = 0;
			while ((framesChecked < FRAMES_TO_CHECK) && (waitCycles < RUN_TIMEOUT))
			begin
				@(posedge PixelClk);
				waitCycles++;
			end
			if (framesChecked < FRAMES_TO_CHECK)
			begin
				timeoutErrors++;
				$display("Timeout: only %0d of %0d frames were checked",
					framesChecked, FRAMES_TO_CHECK);
			end
		end
		$display("Errors: %0d check, %0d timeout", checkErrors, timeoutErrors);
		if ((checkErrors == 0) && (timeoutErrors == 0))
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== sources.f ====
hdl/dviTimingPkg.sv
hdl/tmdsPkg.sv
hdl/videoSyncIf.sv
hdl/videoTimingGen.sv
hdl/tmdsEncoder.sv
hdl/outputSerdes.sv
hdl/dviTransmitter.sv
sim/dviTransmitter_asserts.sv
sim/dviTransmitter_tb.sv
